/* decim_defines.svh */
// ==========================================================
// Build-time sizes for the decimation chain.
// DECIM_FIFO_DEPTH must be a power of two so that the FIFO
// pointers wrap on their own.
// DECIM_MAX_SHIFT bounds the block size at 2^DECIM_MAX_SHIFT
// and widens the accumulators by the same number of bits.
// ==========================================================

`ifndef DECIM_DEFINES_SVH
`define DECIM_DEFINES_SVH

// Width of one signed sample in bits
`define DECIM_SAMPLE_WIDTH 16

// Number of interleaved channels sharing the stream
`define DECIM_N_CHANNELS 4

// Largest decimation exponent, a factor of up to 16
`define DECIM_MAX_SHIFT 4

// Entries in the output FIFO
`define DECIM_FIFO_DEPTH 4

`endif

/* decim_pkg.sv */
// ==========================================================
// Types shared by the decimation chain stages.
// Widths follow the macros in decim_defines.svh.
// accum_t holds a full block sum of 2^DECIM_MAX_SHIFT
// samples without overflow.
// ==========================================================

`default_nettype none

`include "decim_defines.svh"

package decim_pkg;

    typedef logic signed [`DECIM_SAMPLE_WIDTH-1:0] sample_t;

    typedef logic signed [`DECIM_SAMPLE_WIDTH+`DECIM_MAX_SHIFT-1:0] accum_t;

    typedef logic [$clog2(`DECIM_N_CHANNELS)-1:0] channel_t;

    // Holds every exponent from 0 up to DECIM_MAX_SHIFT
    typedef logic [$clog2(`DECIM_MAX_SHIFT+1)-1:0] shift_t;

    typedef enum logic {
        DECIM_PICK,
        DECIM_AVERAGE
    } decim_mode_t;

endpackage

`default_nettype wire

/* sample_stream_if.sv */
// ==========================================================
// One tagged sample stream with a valid/ready handshake.
// A transfer takes place on a clock edge with valid and
// ready both high. The source keeps valid, data and channel
// stable until that transfer.
// ==========================================================

`default_nettype none

interface sample_stream_if import decim_pkg::*; ();

    logic     valid;
    sample_t  data;
    channel_t channel;
    logic     ready;

    modport source (output valid, output data, output channel, input ready);

    modport sink (input valid, input data, input channel, output ready);

endinterface

`default_nettype wire

/* offset_calibrator.sv */
// ==========================================================
// First stage of the chain. Subtracts a per-channel offset
// and clamps the result to the signed sample range.
// An offset written at edge N applies to samples accepted
// from edge N+1 on. Offsets clear to zero on reset.
// Latency is one cycle through a single output register.
// ==========================================================

`default_nettype none

`include "decim_defines.svh"

module offset_calibrator import decim_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     cfg_write,
    input  channel_t cfg_channel,
    input  sample_t  cfg_offset,
    input  logic     in_valid,
    input  sample_t  in_data,
    input  channel_t in_channel,
    output logic     in_ready,
    sample_stream_if.source calibrated
);

    localparam int SW = `DECIM_SAMPLE_WIDTH;
    localparam sample_t SAMPLE_MAX = sample_t'({1'b0, {(SW-1){1'b1}}});
    localparam sample_t SAMPLE_MIN = sample_t'({1'b1, {(SW-1){1'b0}}});

    sample_t offset_table [`DECIM_N_CHANNELS];

    logic signed [SW:0] difference;
    sample_t clamped;
    logic accept;

    // The output register is free when empty or when it drains this cycle
    assign in_ready = !calibrated.valid || calibrated.ready;
    assign accept = in_valid && in_ready;

    // One extra bit keeps the raw difference exact
    assign difference = in_data - offset_table[in_channel];

    always_comb begin
        if (difference[SW] != difference[SW-1]) begin
            clamped = difference[SW] ? SAMPLE_MIN : SAMPLE_MAX;
        end else begin
            clamped = difference[SW-1:0];
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < `DECIM_N_CHANNELS; i++) begin
                offset_table[i] <= '0;
            end
            calibrated.valid <= 1'b0;
        end else begin
            if (cfg_write) begin
                offset_table[cfg_channel] <= cfg_offset;
            end
            if (accept) begin
                calibrated.valid <= 1'b1;
            end else if (calibrated.ready) begin
                calibrated.valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            calibrated.data    <= clamped;
            calibrated.channel <= in_channel;
        end
    end

    // A stalled sample must wait unchanged for the decimator
    stall_hold : assert property (@(posedge clock) disable iff (!reset)
        calibrated.valid && !calibrated.ready |=>
            calibrated.valid && $stable(calibrated.data) && $stable(calibrated.channel));

endmodule

`default_nettype wire

/* stream_decimator.sv */
// ==========================================================
// Second stage of the chain. Each channel keeps its own
// sample count and block sum. Every 2^shift samples it
// forwards either the last sample or the block sum shifted
// right arithmetically by shift.
// mode and shift may change only with no samples in flight.
// A change clears all counts and sums.
// ==========================================================

`default_nettype none

`include "decim_defines.svh"

module stream_decimator import decim_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  decim_mode_t mode,
    input  shift_t      shift,
    sample_stream_if.sink   calibrated,
    sample_stream_if.source decimated
);

    localparam int COUNT_W = `DECIM_MAX_SHIFT;

    logic [COUNT_W-1:0] count_table [`DECIM_N_CHANNELS];
    accum_t             accum_table [`DECIM_N_CHANNELS];

    decim_mode_t mode_q;
    shift_t      shift_q;

    channel_t           channel;
    logic               accept;
    logic               config_changed;
    logic               block_done;
    logic [COUNT_W-1:0] count_current;
    logic [COUNT_W-1:0] block_last;
    accum_t             accum_current;
    accum_t             block_sum;
    sample_t            block_result;

    assign calibrated.ready = !decimated.valid || decimated.ready;
    assign accept = calibrated.valid && calibrated.ready;
    assign channel = calibrated.channel;

    // A new setting discards whatever partial blocks are stored
    assign config_changed = (mode != mode_q) || (shift != shift_q);
    assign count_current = config_changed ? '0 : count_table[channel];
    assign accum_current = config_changed ? '0 : accum_table[channel];

    // Index of the last sample in a block, 2^shift - 1
    assign block_last = ~({COUNT_W{1'b1}} << shift);
    assign block_done = (count_current == block_last);

    assign block_sum = accum_current + accum_t'(calibrated.data);

    always_comb begin
        if (mode == DECIM_AVERAGE) begin
            block_result = sample_t'(block_sum >>> shift);
        end else begin
            block_result = calibrated.data;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < `DECIM_N_CHANNELS; i++) begin
                count_table[i] <= '0;
                accum_table[i] <= '0;
            end
            mode_q <= DECIM_PICK;
            shift_q <= '0;
            decimated.valid <= 1'b0;
        end else begin
            mode_q <= mode;
            shift_q <= shift;
            if (config_changed) begin
                for (int i = 0; i < `DECIM_N_CHANNELS; i++) begin
                    count_table[i] <= '0;
                    accum_table[i] <= '0;
                end
            end
            if (decimated.ready) begin
                decimated.valid <= 1'b0;
            end
            // The accepted channel overrides the clear above
            if (accept) begin
                if (block_done) begin
                    count_table[channel] <= '0;
                    accum_table[channel] <= '0;
                    decimated.valid <= 1'b1;
                end else begin
                    count_table[channel] <= count_current + 1'b1;
                    accum_table[channel] <= (mode == DECIM_AVERAGE) ? block_sum : '0;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept && block_done) begin
            decimated.data    <= block_result;
            decimated.channel <= channel;
        end
    end

    shift_in_range : assert property (@(posedge clock) disable iff (!reset)
        shift <= shift_t'(`DECIM_MAX_SHIFT));

    stall_hold : assert property (@(posedge clock) disable iff (!reset)
        decimated.valid && !decimated.ready |=>
            decimated.valid && $stable(decimated.data) && $stable(decimated.channel));

endmodule

`default_nettype wire

/* output_fifo.sv */
// ==========================================================
// Third stage of the chain. A synchronous FIFO that absorbs
// consumer stalls. An entry written at edge N is visible on
// the outputs after edge N. A write and a read can happen
// in the same cycle, but a full FIFO accepts no write even
// while it is being read.
// ==========================================================

`default_nettype none

`include "decim_defines.svh"

module output_fifo import decim_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    sample_stream_if.sink decimated,
    output logic     out_valid,
    output sample_t  out_data,
    output channel_t out_channel,
    input  logic     out_ready
);

    localparam int DEPTH = `DECIM_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    sample_t  data_mem    [DEPTH];
    channel_t channel_mem [DEPTH];

    logic [PTR_W-1:0] write_ptr;
    logic [PTR_W-1:0] read_ptr;
    logic [PTR_W:0]   count;
    logic             full;
    logic             push;
    logic             pop;

    assign full = (count == (PTR_W+1)'(DEPTH));
    assign decimated.ready = !full;

    // Head entry drives the consumer side
    assign out_valid   = (count != '0);
    assign out_data    = data_mem[read_ptr];
    assign out_channel = channel_mem[read_ptr];

    assign push = decimated.valid && decimated.ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clock) begin
        if (!reset) begin
            write_ptr <= '0;
            read_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                write_ptr <= write_ptr + 1'b1;
            end
            if (pop) begin
                read_ptr <= read_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            data_mem[write_ptr]    <= decimated.data;
            channel_mem[write_ptr] <= decimated.channel;
        end
    end

    // A write into a full buffer would push the occupancy past the depth
    // or let the pointer distance drift away from it
    no_write_when_full : assert property (@(posedge clock) disable iff (!reset)
        (count <= (PTR_W+1)'(DEPTH)) &&
            (PTR_W'(write_ptr - read_ptr) == count[PTR_W-1:0]));

endmodule

`default_nettype wire

/* decimation_chain.sv */
// ==========================================================
// Top level of the multichannel decimation chain.
// Stages in order are offset calibration, decimation and
// an output FIFO, linked by valid/ready streams.
// mode and shift are levels that may change only when no
// samples are in flight.
// ==========================================================

`default_nettype none

module decimation_chain import decim_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        in_valid,
    input  sample_t     in_data,
    input  channel_t    in_channel,
    output logic        in_ready,
    input  logic        cfg_write,
    input  channel_t    cfg_channel,
    input  sample_t     cfg_offset,
    input  decim_mode_t mode,
    input  shift_t      shift,
    output logic        out_valid,
    output sample_t     out_data,
    output channel_t    out_channel,
    input  logic        out_ready
);

    sample_stream_if calibrated ();
    sample_stream_if decimated ();

    offset_calibrator i_offset_calibrator (
        .clock       (clock),
        .reset       (reset),
        .cfg_write   (cfg_write),
        .cfg_channel (cfg_channel),
        .cfg_offset  (cfg_offset),
        .in_valid    (in_valid),
        .in_data     (in_data),
        .in_channel  (in_channel),
        .in_ready    (in_ready),
        .calibrated  (calibrated.source)
    );

    stream_decimator i_stream_decimator (
        .clock      (clock),
        .reset      (reset),
        .mode       (mode),
        .shift      (shift),
        .calibrated (calibrated.sink),
        .decimated  (decimated.source)
    );

    output_fifo i_output_fifo (
        .clock       (clock),
        .reset       (reset),
        .decimated   (decimated.sink),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_channel (out_channel),
        .out_ready   (out_ready)
    );

endmodule

`default_nettype wire

/* tb_decimation_chain.sv */
// ==========================================================
// Directed testbench for the decimation chain.
// Inputs change on the falling clock edge and outputs are
// sampled there as well. Expected results come from a model
// of the offset, clamping and decimation rules.
// The run stops at the first mismatch or timeout.
// ==========================================================

`default_nettype none

`include "decim_defines.svh"

module tb_decimation_chain import decim_pkg::*; ();

    localparam int N_CH = `DECIM_N_CHANNELS;
    localparam int WAIT_LIMIT = 200;
    localparam int SAMPLE_MAX = (1 << (`DECIM_SAMPLE_WIDTH - 1)) - 1;
    localparam int SAMPLE_MIN = -SAMPLE_MAX - 1;

    logic        clock;
    logic        reset;
    logic        in_valid;
    sample_t     in_data;
    channel_t    in_channel;
    logic        in_ready;
    logic        cfg_write;
    channel_t    cfg_channel;
    sample_t     cfg_offset;
    decim_mode_t mode;
    shift_t      shift;
    logic        out_valid;
    sample_t     out_data;
    channel_t    out_channel;
    logic        out_ready;

    int   seed;
    logic stall_enable;
    logic saw_in_stall;

    // Reference model state, one entry per channel
    sample_t model_offset [N_CH];
    int      model_count  [N_CH];
    accum_t  model_accum  [N_CH];

    sample_t  stim_data [$];
    channel_t stim_chan [$];
    sample_t  exp_data  [$];
    channel_t exp_chan  [$];

    decimation_chain i_dut (
        .clock       (clock),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_data     (in_data),
        .in_channel  (in_channel),
        .in_ready    (in_ready),
        .cfg_write   (cfg_write),
        .cfg_channel (cfg_channel),
        .cfg_offset  (cfg_offset),
        .mode        (mode),
        .shift       (shift),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_channel (out_channel),
        .out_ready   (out_ready)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic check_value(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("FAIL at time %0t: %s is %0d, expected %0d", $time, name, actual, expected);
            $display("*** FAILED ***");
            $fatal(1, "simulation stopped at the first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at time %0t while waiting for %s", $time, what);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on a timeout");
    endtask

    function automatic sample_t saturate(input int value);
        if (value > SAMPLE_MAX) begin
            return sample_t'(SAMPLE_MAX);
        end else if (value < SAMPLE_MIN) begin
            return sample_t'(SAMPLE_MIN);
        end
        return sample_t'(value);
    endfunction

    function automatic void clear_model();
        for (int i = 0; i < N_CH; i++) begin
            model_count[i] = 0;
            model_accum[i] = '0;
        end
    endfunction

    // Feeds one input sample through the model under the current mode and shift
    function automatic void model_sample(input channel_t ch, input sample_t d);
        sample_t cal;
        accum_t  sum;
        int      block_size;
        int      mean;
        cal = saturate(int'(d) - int'(model_offset[ch]));
        sum = model_accum[ch] + accum_t'(cal);
        block_size = 1 << shift;
        model_count[ch] = model_count[ch] + 1;
        if (model_count[ch] == block_size) begin
            exp_chan.push_back(ch);
            if (mode == DECIM_AVERAGE) begin
                // Block mean rounded toward minus infinity
                mean = int'(sum) / block_size;
                if (int'(sum) < 0 && mean * block_size != int'(sum)) begin
                    mean = mean - 1;
                end
                exp_data.push_back(sample_t'(mean));
            end else begin
                exp_data.push_back(cal);
            end
            model_count[ch] = 0;
            model_accum[ch] = '0;
        end else begin
            model_accum[ch] = sum;
        end
    endfunction

    task automatic set_config(input decim_mode_t new_mode, input int new_shift);
        @(negedge clock);
        // The DUT drops partial blocks whenever mode or shift changes
        if (new_mode != mode || shift_t'(new_shift) != shift) begin
            clear_model();
        end
        mode = new_mode;
        shift = shift_t'(new_shift);
        @(negedge clock);
    endtask

    task automatic write_offset(input int ch, input int value);
        @(negedge clock);
        cfg_write = 1'b1;
        cfg_channel = channel_t'(ch);
        cfg_offset = sample_t'(value);
        @(negedge clock);
        cfg_write = 1'b0;
        model_offset[ch] = sample_t'(value);
    endtask

    task automatic add_stim(input int ch, input int value);
        stim_chan.push_back(channel_t'(ch));
        stim_data.push_back(sample_t'(value));
    endtask

    task automatic send_all();
        int waited;
        for (int i = 0; i < stim_data.size(); i++) begin
            in_valid = 1'b1;
            in_data = stim_data[i];
            in_channel = stim_chan[i];
            waited = 0;
            while (!in_ready) begin
                saw_in_stall = 1'b1;
                // Input stalls only when the output side holds data
                check_value("out_valid while in_ready is low", out_valid, 1);
                @(negedge clock);
                waited++;
                if (waited > WAIT_LIMIT) begin
                    report_timeout("in_ready to accept a sample");
                end
            end
            @(negedge clock);
        end
        in_valid = 1'b0;
    endtask

    task automatic collect_all(input int total);
        int got;
        int waited;
        got = 0;
        waited = 0;
        while (got < total) begin
            @(negedge clock);
            out_ready = stall_enable ? 1'($random(seed)) : 1'b1;
            if (out_valid && out_ready) begin
                check_value("out_channel", out_channel, exp_chan[got]);
                check_value("out_data", out_data, exp_data[got]);
                got++;
                waited = 0;
            end else begin
                waited++;
                if (waited > WAIT_LIMIT) begin
                    report_timeout("out_valid with the next expected result");
                end
            end
        end
        out_ready = 1'b1;
    endtask

    task automatic run_burst();
        exp_data.delete();
        exp_chan.delete();
        for (int i = 0; i < stim_data.size(); i++) begin
            model_sample(stim_chan[i], stim_data[i]);
        end
        fork
            send_all();
            collect_all(exp_data.size());
        join
        // Nothing may follow the last expected result
        repeat (4) @(negedge clock);
        check_value("out_valid after drain", out_valid, 0);
        stim_data.delete();
        stim_chan.delete();
    endtask

    task automatic test_reset_and_passthrough();
        check_value("out_valid after reset", out_valid, 0);
        check_value("in_ready after reset", in_ready, 1);
        set_config(DECIM_PICK, 0);
        for (int i = 0; i < 12; i++) begin
            add_stim(i % N_CH, $random(seed));
        end
        run_burst();
    endtask

    task automatic test_offsets();
        write_offset(0, 100);
        write_offset(1, -200);
        write_offset(2, 32000);
        write_offset(3, -32000);
        add_stim(2, SAMPLE_MIN);
        add_stim(3, SAMPLE_MAX);
        add_stim(2, SAMPLE_MAX);
        add_stim(3, SAMPLE_MIN);
        for (int i = 0; i < 16; i++) begin
            add_stim(i % N_CH, $random(seed));
        end
        run_burst();
    endtask

    task automatic test_pick_shift2();
        set_config(DECIM_PICK, 2);
        for (int i = 0; i < 32; i++) begin
            add_stim(i % N_CH, $random(seed));
        end
        run_burst();
    endtask

    task automatic test_average_shift3();
        write_offset(2, 50);
        write_offset(3, -75);
        set_config(DECIM_AVERAGE, 3);
        for (int i = 0; i < 64; i++) begin
            add_stim($random(seed) & (N_CH - 1), $random(seed));
        end
        run_burst();
    endtask

    task automatic test_random_stalls();
        set_config(DECIM_PICK, 0);
        stall_enable = 1'b1;
        saw_in_stall = 1'b0;
        for (int i = 0; i < 48; i++) begin
            add_stim($random(seed) & (N_CH - 1), $random(seed));
        end
        run_burst();
        stall_enable = 1'b0;
        check_value("in_ready stall seen", saw_in_stall, 1);
    endtask

    task automatic test_config_changes();
        set_config(DECIM_AVERAGE, 2);
        for (int i = 0; i < 6; i++) begin
            add_stim(0, $random(seed));
        end
        for (int i = 0; i < 3; i++) begin
            add_stim(1, $random(seed));
        end
        run_burst();
        // Channels 0 and 1 now hold partial blocks that must be dropped
        set_config(DECIM_AVERAGE, 1);
        for (int i = 0; i < 8; i++) begin
            add_stim(i % 2, $random(seed));
        end
        run_burst();
        set_config(DECIM_PICK, 1);
        for (int i = 0; i < 3; i++) begin
            add_stim(2, $random(seed));
        end
        run_burst();
        set_config(DECIM_PICK, 2);
        for (int i = 0; i < 8; i++) begin
            add_stim(2, $random(seed));
        end
        run_burst();
    endtask

    initial begin
        seed = 32'hb0c0096c;
        reset = 1'b0;
        in_valid = 1'b0;
        in_data = '0;
        in_channel = '0;
        cfg_write = 1'b0;
        cfg_channel = '0;
        cfg_offset = '0;
        mode = DECIM_PICK;
        shift = '0;
        out_ready = 1'b1;
        stall_enable = 1'b0;
        saw_in_stall = 1'b0;
        for (int i = 0; i < N_CH; i++) begin
            model_offset[i] = '0;
        end
        clear_model();
        repeat (5) @(negedge clock);
        reset = 1'b1;
        test_reset_and_passthrough();
        test_offsets();
        test_pick_shift2();
        test_average_shift3();
        test_random_stalls();
        test_config_changes();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* decimation_chain.f */
+incdir+.
decim_pkg.sv
sample_stream_if.sv
offset_calibrator.sv
stream_decimator.sv
output_fifo.sv
decimation_chain.sv
tb_decimation_chain.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the decimation chain testbench with Verilator and runs it.
# The run counts as failed when the log holds the fail message
# or when the simulator exits with an error status.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_decimation_chain \
    --Mdir "$build_dir" -o sim_tb \
    -f decimation_chain.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/sim_tb" > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if grep -q -F "*** FAILED ***" "$log_file"; then
    echo "Simulation failed, see $log_file"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulator exited with status $run_status"
    exit 1
fi
echo "Simulation finished without errors"
exit 0
